// File: tb.f
+incdir+testbench
common/isa_pkg.sv
common/pipe_pkg.sv
common/muldiv_if.sv
source/alu.sv
muldiv/multiplier.sv
muldiv/divider.sv
source/step_counter.sv
source/execute_control.sv
source/execute_stage.sv
testbench/tb_execute.sv

// File: testbench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Expected results from the RV32IM rules

function automatic logic [31:0] alu_result_of(alu_op_e op, logic [31:0] a, logic [31:0] b);
	logic [4:0] shamt;
	logic [31:0] fill;
	shamt = b[4:0];
	// Sign bits that an arithmetic shift pulls in from the left
	fill = ~(32'hffff_ffff >> shamt) & {32{a[31]}};
	case (op)
		ALU_SUB: return a + ~b + 32'd1;
		ALU_XOR: return a ^ b;
		ALU_OR:  return a | b;
		ALU_AND: return a & b;
		ALU_SLL: return a << shamt;
		ALU_SRL: return a >> shamt;
		ALU_SRA: return (a >> shamt) | fill;
		default: return a + b;
	endcase
endfunction

function automatic logic compare_taken(alu_op_e op, logic [31:0] a, logic [31:0] b);
	logic signed_less;
	logic unsigned_less;
	unsigned_less = a < b;
	// Flipping the sign bit maps signed order onto unsigned order
	signed_less = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
	case (op)
		ALU_EQ:  return a == b;
		ALU_NE:  return a != b;
		ALU_LT:  return signed_less;
		ALU_GE:  return !signed_less;
		ALU_LTU: return unsigned_less;
		ALU_GEU: return !unsigned_less;
		default: return 1'b0;
	endcase
endfunction

function automatic logic [31:0] branch_target(logic [31:0] pc, logic [31:0] imm, logic taken);
	return taken ? pc + imm : pc + 32'd4;
endfunction

function automatic logic [31:0] muldiv_result_of(muldiv_op_e op, logic [31:0] a, logic [31:0] b);
	logic signed [63:0] signed_product;
	logic [63:0] unsigned_product;
	logic signed [31:0] sa;
	logic signed [31:0] sb;
	logic overflow;
	sa = a;
	sb = b;
	signed_product = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
	unsigned_product = {32'd0, a} * {32'd0, b};
	overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
	case (op)
		MD_MUL:   return unsigned_product[31:0];
		MD_MULH:  return signed_product[63:32];
		MD_MULHU: return unsigned_product[63:32];
		MD_DIV: begin
			if (b == 32'd0)
				return 32'hffff_ffff;
			else if (overflow)
				return a;
			else
				return sa / sb;
		end
		MD_DIVU: return (b == 32'd0) ? 32'hffff_ffff : a / b;
		MD_REM: begin
			if (b == 32'd0)
				return a;
			else if (overflow)
				return 32'd0;
			else
				return sa % sb;
		end
		default: return (b == 32'd0) ? a : a % b;
	endcase
endfunction

`endif

// File: testbench/tb_execute.sv
`timescale 1ns/1ns
`default_nettype none

module tb_execute;

	import isa_pkg::*;
	import pipe_pkg::*;

	`include "tb_model.svh"

	localparam int TIMEOUT = 200;

	logic i_clock;
	logic i_reset;
	decode_data_t i_data;
	logic [31:0] i_rs1;
	logic [31:0] i_rs2;
	logic i_memory_busy;
	logic o_busy;
	execute_data_t o_data;
	logic o_jump;
	logic [31:0] o_jump_pc;
	logic o_fault;

	integer seed;
	int errors;
	int checks;
	logic [3:0] next_tag;
	logic [31:0] corners [5];

	execute_stage #(
		.TAG_WIDTH(4)
	) u_dut (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_data(i_data),
		.i_rs1(i_rs1),
		.i_rs2(i_rs2),
		.i_memory_busy(i_memory_busy),
		.o_busy(o_busy),
		.o_data(o_data),
		.o_jump(o_jump),
		.o_jump_pc(o_jump_pc),
		.o_fault(o_fault)
	);

	initial begin
		i_clock = 1'b0;
		forever #2 i_clock = ~i_clock;
	end

	// ==============================
	// Protocol checks

	assert property (@(posedge i_clock) disable iff (i_reset) o_jump |=> !o_jump)
	else begin
		errors++;
		$display("o_jump stayed high for more than one cycle");
	end

	assert property (@(posedge i_clock) disable iff (i_reset) i_memory_busy |-> o_busy)
	else begin
		errors++;
		$display("o_busy was low while memory was busy");
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		assert (got === expected)
		else begin
			errors++;
			$display("FAILED %s: got %h expected %h", name, got, expected);
		end
	endtask

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	endtask

	task automatic drive_instr(input decode_data_t d, input logic [31:0] rs1,
			input logic [31:0] rs2, output logic [3:0] tag);
		decode_data_t word;
		word = d;
		word.tag = next_tag;
		tag = next_tag;
		next_tag = next_tag + 4'd1;
		i_data = word;
		i_rs1 = rs1;
		i_rs2 = rs2;
	endtask

	// Counts clocks until the tag shows up, with an optional memory stall
	task automatic wait_done(input logic [3:0] tag, input int busy_at, input int busy_len,
			input logic expect_busy, output int cycles);
		cycles = 0;
		while (o_data.tag !== tag && cycles < TIMEOUT) begin
			@(negedge i_clock);
			cycles++;
			if (busy_at > 0 && cycles == busy_at)
				i_memory_busy = 1'b1;
			if (busy_at > 0 && cycles == busy_at + busy_len)
				i_memory_busy = 1'b0;
			if (expect_busy && o_data.tag !== tag)
				check_value("o_busy", 32'(o_busy), 32'd1);
		end
		if (o_data.tag !== tag) begin
			errors++;
			$display("Instruction with tag %0h did not complete within %0d cycles",
				tag, TIMEOUT);
			finish_run();
		end
	endtask

	task automatic reset_outputs_zero();
		check_value("o_data.tag", 32'(o_data.tag), 32'd0);
		check_value("o_data.rd_index", 32'(o_data.rd_index), 32'd0);
		check_value("o_data.rd", o_data.rd, 32'd0);
		check_value("o_data.mem_read", 32'(o_data.mem_read), 32'd0);
		check_value("o_data.mem_write", 32'(o_data.mem_write), 32'd0);
		check_value("o_data.mem_width", 32'(o_data.mem_width), 32'd0);
		check_value("o_data.mem_signed", 32'(o_data.mem_signed), 32'd0);
		check_value("o_data.mem_address", o_data.mem_address, 32'd0);
		check_value("o_jump", 32'(o_jump), 32'd0);
		check_value("o_jump_pc", o_jump_pc, 32'd0);
		check_value("o_fault", 32'(o_fault), 32'd0);
		check_value("o_busy", 32'(o_busy), 32'(i_memory_busy));
	endtask

	// ==============================
	// Single cycle classes

	task automatic single_cycle_results(input int count);
		decode_data_t d;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] operand2;
		logic [31:0] expected;
		logic [3:0] tag;
		int k;
		int n;
		int cycles;
		for (n = 0; n < count; n++) begin
			k = {$random(seed)} % 14;
			a = $random(seed);
			b = $random(seed);
			d = '0;
			d.alu_op = alu_op_e'(k);
			d.pc = $random(seed);
			d.imm = $random(seed);
			d.rd_index = 5'(n);
			d.operand1_sel = SEL_RS1;
			d.operand2_sel = ($random(seed) & 1) ? SEL_IMM : SEL_RS2;
			if (k < 5)
				d.exec_class = CLASS_ARITH;
			else if (k < 8)
				d.exec_class = CLASS_SHIFT;
			else
				d.exec_class = CLASS_COMPARE;
			operand2 = (d.operand2_sel == SEL_IMM) ? d.imm : b;
			if (d.exec_class == CLASS_COMPARE)
				expected = {31'd0, compare_taken(d.alu_op, a, operand2)};
			else
				expected = alu_result_of(d.alu_op, a, operand2);
			drive_instr(d, a, b, tag);
			wait_done(tag, 0, 0, 1'b0, cycles);
			check_value("completion cycles", 32'(cycles), 32'd1);
			check_value("o_data.rd", o_data.rd, expected);
			check_value("o_data.rd_index", 32'(o_data.rd_index), 32'(d.rd_index));
		end
	endtask

	task automatic jumps_and_branches(input int count);
		decode_data_t d;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] target;
		logic [3:0] tag;
		int n;
		int cycles;
		for (n = 0; n < count; n++) begin
			a = $random(seed);
			b = (n % 3 == 0) ? a : $random(seed);
			d = '0;
			d.pc = $random(seed) & 32'hffff_fffc;
			d.imm = $random(seed);
			d.rd_index = 5'd1;
			if (n % 2 == 0) begin
				// jal and jalr alternate
				d.exec_class = CLASS_JUMP;
				d.alu_op = ALU_ADD;
				d.operand1_sel = (n % 4 == 0) ? SEL_PC : SEL_RS1;
				d.operand2_sel = SEL_IMM;
				target = ((n % 4 == 0) ? d.pc : a) + d.imm;
			end
			else begin
				d.exec_class = CLASS_BRANCH;
				d.alu_op = alu_op_e'(8 + {$random(seed)} % 6);
				d.operand1_sel = SEL_RS1;
				d.operand2_sel = SEL_RS2;
				target = branch_target(d.pc, d.imm, compare_taken(d.alu_op, a, b));
			end
			drive_instr(d, a, b, tag);
			wait_done(tag, 0, 0, 1'b0, cycles);
			check_value("completion cycles", 32'(cycles), 32'd1);
			check_value("o_jump", 32'(o_jump), 32'd1);
			check_value("o_jump_pc", o_jump_pc, target);
			if (d.exec_class == CLASS_JUMP)
				check_value("o_data.rd", o_data.rd, d.pc + 32'd4);
			@(negedge i_clock);
			check_value("o_jump", 32'(o_jump), 32'd0);
		end
	endtask

	task automatic loads_and_stores(input int count);
		decode_data_t d;
		logic [31:0] a;
		logic [31:0] b;
		logic [3:0] tag;
		logic store;
		int n;
		int cycles;
		for (n = 0; n < count; n++) begin
			store = n[0];
			a = $random(seed);
			b = $random(seed);
			d = '0;
			d.exec_class = store ? CLASS_STORE : CLASS_LOAD;
			d.alu_op = ALU_ADD;
			d.operand1_sel = SEL_RS1;
			d.operand2_sel = SEL_IMM;
			d.imm = $random(seed);
			d.rd_index = 5'(n + 3);
			d.mem_width = 2'($random(seed));
			d.mem_signed = 1'($random(seed));
			drive_instr(d, a, b, tag);
			wait_done(tag, 0, 0, 1'b0, cycles);
			check_value("completion cycles", 32'(cycles), 32'd1);
			check_value("o_data.mem_address", o_data.mem_address, a + d.imm);
			check_value("o_data.mem_read", 32'(o_data.mem_read), 32'(!store));
			check_value("o_data.mem_write", 32'(o_data.mem_write), 32'(store));
			check_value("o_data.mem_width", 32'(o_data.mem_width), 32'(d.mem_width));
			check_value("o_data.mem_signed", 32'(o_data.mem_signed), 32'(d.mem_signed));
			if (store)
				check_value("o_data.rd", o_data.rd, b);
		end
	endtask

	// ==============================
	// Multiply and divide

	task automatic muldiv_results(input muldiv_op_e op, input int expected_cycles);
		decode_data_t d;
		logic [31:0] a;
		logic [31:0] b;
		logic [3:0] tag;
		int n;
		int cycles;
		for (n = 0; n < 10; n++) begin
			a = (n < 5) ? corners[n] : $random(seed);
			if (n < 5)
				b = corners[(n + 4) % 5];
			else if (n == 5)
				b = 32'd0;
			else
				b = $random(seed);
			d = '0;
			d.exec_class = CLASS_MULDIV;
			d.muldiv_op = op;
			d.rd_index = 5'(n + 10);
			drive_instr(d, a, b, tag);
			wait_done(tag, 0, 0, 1'b1, cycles);
			check_value("completion cycles", 32'(cycles), 32'(expected_cycles));
			check_value("o_data.rd", o_data.rd, muldiv_result_of(op, a, b));
			check_value("o_busy", 32'(o_busy), 32'd0);
		end
	endtask

	task automatic back_pressure();
		decode_data_t d;
		logic [31:0] a;
		logic [31:0] b;
		logic [3:0] tag;
		logic [3:0] prev_tag;
		int cycles;
		a = 32'hfedc_ba98;
		b = 32'h0000_0123;
		d = '0;
		d.exec_class = CLASS_MULDIV;
		d.muldiv_op = MD_DIV;
		drive_instr(d, a, b, tag);
		// Seven stalled clocks in the middle of the divide
		wait_done(tag, 5, 7, 1'b1, cycles);
		check_value("completion cycles", 32'(cycles), 32'(DIV_STEPS + 2 + 7));
		check_value("o_data.rd", o_data.rd, muldiv_result_of(MD_DIV, a, b));

		i_memory_busy = 1'b1;
		prev_tag = o_data.tag;
		d = '0;
		d.exec_class = CLASS_ARITH;
		d.alu_op = ALU_ADD;
		d.operand1_sel = SEL_RS1;
		d.operand2_sel = SEL_RS2;
		drive_instr(d, a, b, tag);
		repeat (4) @(negedge i_clock);
		check_value("o_data.tag", 32'(o_data.tag), 32'(prev_tag));
		check_value("o_busy", 32'(o_busy), 32'd1);
		i_memory_busy = 1'b0;
		wait_done(tag, 0, 0, 1'b0, cycles);
		check_value("completion cycles", 32'(cycles), 32'd1);
		check_value("o_data.rd", o_data.rd, a + b);
	endtask

	task automatic fault_and_reset();
		decode_data_t d;
		logic [3:0] tag;
		logic [3:0] prev_tag;
		int cycles;
		prev_tag = o_data.tag;
		d = '0;
		d.exec_class = CLASS_NONE;
		drive_instr(d, 32'd0, 32'd0, tag);
		cycles = 0;
		while (o_fault !== 1'b1 && cycles < TIMEOUT) begin
			@(negedge i_clock);
			cycles++;
		end
		if (o_fault !== 1'b1) begin
			errors++;
			$display("o_fault did not rise for an instruction of class none");
		end
		else begin
			check_value("o_data.tag", 32'(o_data.tag), 32'(prev_tag));
			// Fault stays set until the next reset
			i_data = '0;
			i_reset = 1'b1;
			repeat (2) @(negedge i_clock);
			i_reset = 1'b0;
			next_tag = 4'd1;
			reset_outputs_zero();
		end
	endtask

	initial begin
		seed = 32'hd8715cea;
		errors = 0;
		checks = 0;
		next_tag = 4'd1;
		corners[0] = 32'h0000_0000;
		corners[1] = 32'h0000_0001;
		corners[2] = 32'hffff_ffff;
		corners[3] = 32'h8000_0000;
		corners[4] = 32'h7fff_ffff;
		i_reset = 1'b1;
		i_data = '0;
		i_rs1 = '0;
		i_rs2 = '0;
		i_memory_busy = 1'b0;
		repeat (2) @(negedge i_clock);
		i_reset = 1'b0;
		reset_outputs_zero();

		single_cycle_results(40);
		jumps_and_branches(16);
		loads_and_stores(8);
		muldiv_results(MD_MUL, 3);
		muldiv_results(MD_MULH, 3);
		muldiv_results(MD_MULHU, 3);
		muldiv_results(MD_DIV, DIV_STEPS + 2);
		muldiv_results(MD_DIVU, DIV_STEPS + 2);
		muldiv_results(MD_REM, DIV_STEPS + 2);
		muldiv_results(MD_REMU, DIV_STEPS + 2);
		back_pressure();
		fault_and_reset();
		finish_run();
	end

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage #(
	parameter int TAG_WIDTH = 4
) (
	input wire i_clock,
	input wire i_reset,
	input wire pipe_pkg::decode_data_t i_data,
	input wire [31:0] i_rs1,
	input wire [31:0] i_rs2,
	input wire i_memory_busy,
	output logic o_busy,
	output pipe_pkg::execute_data_t o_data,
	output logic o_jump,
	output logic [31:0] o_jump_pc,
	output logic o_fault
);

	localparam int WORD_WIDTH = 32;

	wire isa_pkg::alu_op_e alu_op;
	wire [31:0] alu_operand1;
	wire [31:0] alu_operand2;
	wire [31:0] alu_result;
	wire alu_compare;

	wire count_load;
	wire [5:0] count_value;
	wire count_enable;
	wire count_expired;

	muldiv_if #(.WIDTH(WORD_WIDTH)) muldiv ();

	execute_control #(
		.TAG_WIDTH(TAG_WIDTH)
	) control (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_data(i_data),
		.i_rs1(i_rs1),
		.i_rs2(i_rs2),
		.i_memory_busy(i_memory_busy),
		.i_alu_result(alu_result),
		.i_alu_compare(alu_compare),
		.o_alu_op(alu_op),
		.o_alu_operand1(alu_operand1),
		.o_alu_operand2(alu_operand2),
		.o_count_load(count_load),
		.o_count_value(count_value),
		.o_count_enable(count_enable),
		.i_count_expired(count_expired),
		.muldiv(muldiv.control),
		.o_busy(o_busy),
		.o_data(o_data),
		.o_jump(o_jump),
		.o_jump_pc(o_jump_pc),
		.o_fault(o_fault)
	);

	alu alu (
		.i_op(alu_op),
		.i_operand1(alu_operand1),
		.i_operand2(alu_operand2),
		.o_result(alu_result),
		.o_compare(alu_compare)
	);

	step_counter counter (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_load(count_load),
		.i_value(count_value),
		.i_enable(count_enable),
		.o_expired(count_expired)
	);

	multiplier #(.WIDTH(WORD_WIDTH)) multiply (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.muldiv(muldiv.mul)
	);

	divider #(.WIDTH(WORD_WIDTH)) divide (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.muldiv(muldiv.div)
	);

endmodule

`default_nettype wire

// File: source/execute_control.sv
`timescale 1ns/1ns
`default_nettype none

module execute_control #(
	parameter int TAG_WIDTH = 4
) (
	input wire i_clock,
	input wire i_reset,
	input wire pipe_pkg::decode_data_t i_data,
	input wire [31:0] i_rs1,
	input wire [31:0] i_rs2,
	input wire i_memory_busy,
	input wire [31:0] i_alu_result,
	input wire i_alu_compare,
	output isa_pkg::alu_op_e o_alu_op,
	output logic [31:0] o_alu_operand1,
	output logic [31:0] o_alu_operand2,
	output logic o_count_load,
	output logic [5:0] o_count_value,
	output logic o_count_enable,
	input wire i_count_expired,
	muldiv_if.control muldiv,
	output logic o_busy,
	output pipe_pkg::execute_data_t o_data,
	output logic o_jump,
	output logic [31:0] o_jump_pc,
	output logic o_fault
);

	import isa_pkg::*;
	import pipe_pkg::*;

	// Product is ready after two clocks in mul_wait
	localparam logic [5:0] MUL_WAIT_COUNT = 6'd1;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_MUL_WAIT,
		ST_DIV_RUN
	} state_e;

	state_e state;
	muldiv_op_e op_latched;
	muldiv_op_e active_op;

	logic offered;
	logic accept_muldiv;
	logic single_cycle;
	logic single_done;
	logic muldiv_done;
	logic take_jump;
	logic [31:0] jump_target;
	logic [31:0] rd_next;
	logic [31:0] muldiv_result;
	logic [31:0] pc_next;

	function automatic logic [31:0] select_operand(input operand_sel_e sel);
		case (sel)
			SEL_RS1: return i_rs1;
			SEL_RS2: return i_rs2;
			SEL_PC:  return i_data.pc;
			SEL_IMM: return i_data.imm;
			default: return 32'd0;
		endcase
	endfunction

	assign o_alu_op = i_data.alu_op;
	assign o_alu_operand1 = select_operand(i_data.operand1_sel);
	assign o_alu_operand2 = select_operand(i_data.operand2_sel);

	assign offered = (i_data.tag[TAG_WIDTH-1:0] != o_data.tag[TAG_WIDTH-1:0]);
	assign o_busy = i_memory_busy || (offered && i_data.exec_class == CLASS_MULDIV);
	assign pc_next = i_data.pc + 32'd4;

	// ==============================
	// Multiply and divide sequencing

	assign accept_muldiv = (state == ST_IDLE) && offered && !i_memory_busy &&
		(i_data.exec_class == CLASS_MULDIV);
	assign active_op = (state == ST_IDLE) ? i_data.muldiv_op : op_latched;

	assign muldiv.start = accept_muldiv;
	assign muldiv.step = (state == ST_DIV_RUN) && !i_memory_busy && !i_count_expired;
	assign muldiv.is_signed = (active_op == MD_DIV) || (active_op == MD_REM);
	assign muldiv.op1_signed = (active_op == MD_MULH);
	assign muldiv.op2_signed = (active_op == MD_MULH);
	assign muldiv.operand_a = i_rs1;
	assign muldiv.operand_b = i_rs2;

	assign o_count_load = accept_muldiv;
	assign o_count_value = (i_data.muldiv_op inside {MD_DIV, MD_DIVU, MD_REM, MD_REMU}) ?
		6'(DIV_STEPS) : MUL_WAIT_COUNT;
	assign o_count_enable = (state != ST_IDLE) && !i_memory_busy;

	always_comb begin
		case (op_latched)
			MD_MUL: muldiv_result = muldiv.product[31:0];
			MD_MULH, MD_MULHU: muldiv_result = muldiv.product[63:32];
			MD_DIV, MD_DIVU: muldiv_result = muldiv.quotient;
			default: muldiv_result = muldiv.remainder;
		endcase
	end

	// ==============================
	// Result selection

	always_comb begin
		rd_next = o_data.rd;
		single_cycle = 1'b1;
		take_jump = 1'b0;
		jump_target = pc_next;
		case (i_data.exec_class)
			CLASS_ARITH, CLASS_SHIFT: rd_next = i_alu_result;
			CLASS_COMPARE: rd_next = {31'd0, i_alu_compare};
			CLASS_JUMP: begin
				rd_next = pc_next;
				take_jump = 1'b1;
				jump_target = i_alu_result;
			end
			CLASS_BRANCH: begin
				take_jump = 1'b1;
				if (i_alu_compare)
					jump_target = i_data.pc + i_data.imm;
			end
			CLASS_LOAD: ;
			CLASS_STORE: rd_next = i_rs2;
			default: single_cycle = 1'b0;
		endcase
		if (state != ST_IDLE)
			rd_next = muldiv_result;
	end

	assign single_done = (state == ST_IDLE) && offered && single_cycle;
	assign muldiv_done = (state != ST_IDLE) && i_count_expired;

	always_ff @(posedge i_clock) begin
		if (accept_muldiv)
			op_latched <= i_data.muldiv_op;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			o_data <= '0;
			o_jump <= 1'b0;
			o_jump_pc <= '0;
			o_fault <= 1'b0;
		end
		else begin
			o_jump <= 1'b0;
			if (!i_memory_busy) begin
				if (single_done || muldiv_done) begin
					o_data.tag <= i_data.tag;
					o_data.rd_index <= i_data.rd_index;
					o_data.rd <= rd_next;
					o_data.mem_read <= (i_data.exec_class == CLASS_LOAD);
					o_data.mem_write <= (i_data.exec_class == CLASS_STORE);
					o_data.mem_width <= i_data.mem_width;
					o_data.mem_signed <= i_data.mem_signed;
					o_data.mem_address <= i_alu_result;
					state <= ST_IDLE;
				end
				if (single_done && take_jump) begin
					o_jump <= 1'b1;
					o_jump_pc <= jump_target;
				end
				if (accept_muldiv)
					state <= muldiv.is_signed || i_data.muldiv_op inside {MD_DIVU, MD_REMU} ?
						ST_DIV_RUN : ST_MUL_WAIT;
				// Unknown class points to a decode bug
				if (state == ST_IDLE && offered && !single_cycle &&
						i_data.exec_class != CLASS_MULDIV)
					o_fault <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/step_counter.sv
`timescale 1ns/1ns
`default_nettype none

module step_counter (
	input wire i_clock,
	input wire i_reset,
	input wire i_load,
	input wire [5:0] i_value,
	input wire i_enable,
	output logic o_expired
);

	logic [5:0] count;

	always_ff @(posedge i_clock) begin
		if (i_reset)
			count <= '0;
		else if (i_load)
			count <= i_value;
		else if (i_enable && count != '0)
			count <= count - 6'd1;
	end

	// A pending load hides the old zero count
	assign o_expired = (count == '0) && !i_load;

endmodule

`default_nettype wire

// File: muldiv/divider.sv
`timescale 1ns/1ns
`default_nettype none

module divider #(
	parameter int WIDTH = 32
) (
	input wire i_clock,
	input wire i_reset,
	muldiv_if.div muldiv
);

	logic [WIDTH-1:0] remainder_mag;
	logic [WIDTH-1:0] quotient_mag;
	logic [WIDTH-1:0] divisor_mag;
	logic negate_quotient;
	logic negate_remainder;

	logic dividend_negative;
	logic divisor_negative;
	logic [WIDTH:0] partial;
	logic [WIDTH:0] difference;

	assign dividend_negative = muldiv.is_signed && muldiv.operand_a[WIDTH-1];
	assign divisor_negative = muldiv.is_signed && muldiv.operand_b[WIDTH-1];

	// Next dividend bit comes off the top of the quotient register
	always_comb begin
		partial = {remainder_mag, quotient_mag[WIDTH-1]};
		difference = partial - {1'b0, divisor_mag};
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			remainder_mag <= '0;
			quotient_mag <= '0;
			divisor_mag <= '0;
			negate_quotient <= 1'b0;
			negate_remainder <= 1'b0;
		end
		else if (muldiv.start) begin
			remainder_mag <= '0;
			quotient_mag <= dividend_negative ? -muldiv.operand_a : muldiv.operand_a;
			divisor_mag <= divisor_negative ? -muldiv.operand_b : muldiv.operand_b;
			// Divide by zero keeps the all ones quotient
			negate_quotient <= (dividend_negative ^ divisor_negative) &&
				(muldiv.operand_b != '0);
			negate_remainder <= dividend_negative;
		end
		else if (muldiv.step) begin
			if (!difference[WIDTH])
				remainder_mag <= difference[WIDTH-1:0];
			else
				remainder_mag <= partial[WIDTH-1:0];
			quotient_mag <= {quotient_mag[WIDTH-2:0], !difference[WIDTH]};
		end
	end

	// ==============================
	// Sign correction
	//
	// Most negative over -1 needs nothing special because its magnitude
	// negates back onto itself with a zero remainder

	assign muldiv.quotient = negate_quotient ? -quotient_mag : quotient_mag;
	assign muldiv.remainder = negate_remainder ? -remainder_mag : remainder_mag;

endmodule

`default_nettype wire

// File: muldiv/multiplier.sv
`timescale 1ns/1ns
`default_nettype none

module multiplier #(
	parameter int WIDTH = 32
) (
	input wire i_clock,
	input wire i_reset,
	muldiv_if.mul muldiv
);

	// One extra bit so unsigned operands survive a signed multiply
	logic signed [WIDTH:0] factor_a;
	logic signed [WIDTH:0] factor_b;
	logic signed [2*WIDTH+1:0] product_full;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			factor_a <= '0;
			factor_b <= '0;
			product_full <= '0;
		end
		else begin
			factor_a <= {muldiv.op1_signed && muldiv.operand_a[WIDTH-1], muldiv.operand_a};
			factor_b <= {muldiv.op2_signed && muldiv.operand_b[WIDTH-1], muldiv.operand_b};
			product_full <= factor_a * factor_b;
		end
	end

	assign muldiv.product = product_full[2*WIDTH-1:0];

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input wire isa_pkg::alu_op_e i_op,
	input wire [31:0] i_operand1,
	input wire [31:0] i_operand2,
	output logic [31:0] o_result,
	output logic o_compare
);

	import isa_pkg::*;

	logic [31:0] sum;
	logic [31:0] shift_result;
	logic [4:0] shift_amount;

	assign shift_amount = i_operand2[4:0];

	always_comb begin
		if (i_op == ALU_SUB)
			sum = i_operand1 - i_operand2;
		else
			sum = i_operand1 + i_operand2;
	end

	// ==============================
	// Shifter

	always_comb begin
		case (i_op)
			ALU_SLL: shift_result = i_operand1 << shift_amount;
			ALU_SRA: shift_result = $signed(i_operand1) >>> shift_amount;
			default: shift_result = i_operand1 >> shift_amount;
		endcase
	end

	// Sum is the fallback that loads and stores rely on
	always_comb begin
		case (i_op)
			ALU_XOR: o_result = i_operand1 ^ i_operand2;
			ALU_OR:  o_result = i_operand1 | i_operand2;
			ALU_AND: o_result = i_operand1 & i_operand2;
			ALU_SLL, ALU_SRL, ALU_SRA: o_result = shift_result;
			default: o_result = sum;
		endcase
	end

	// ==============================
	// Comparator

	always_comb begin
		case (i_op)
			ALU_EQ:  o_compare = (i_operand1 == i_operand2);
			ALU_NE:  o_compare = (i_operand1 != i_operand2);
			ALU_LT:  o_compare = ($signed(i_operand1) < $signed(i_operand2));
			ALU_GE:  o_compare = ($signed(i_operand1) >= $signed(i_operand2));
			ALU_LTU: o_compare = (i_operand1 < i_operand2);
			ALU_GEU: o_compare = (i_operand1 >= i_operand2);
			default: o_compare = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: common/muldiv_if.sv
`timescale 1ns/1ns
`default_nettype none

interface muldiv_if #(
	parameter int WIDTH = 32
);

	logic start;
	logic step;
	logic is_signed;
	logic op1_signed;
	logic op2_signed;

	// Dividend or multiplicand, divisor or multiplier
	logic [WIDTH-1:0] operand_a;
	logic [WIDTH-1:0] operand_b;

	logic [2*WIDTH-1:0] product;
	logic [WIDTH-1:0] quotient;
	logic [WIDTH-1:0] remainder;

	modport control (
		output start, step, is_signed, op1_signed, op2_signed, operand_a, operand_b,
		input product, quotient, remainder
	);

	modport mul (
		input op1_signed, op2_signed, operand_a, operand_b,
		output product
	);

	modport div (
		input start, step, is_signed, operand_a, operand_b,
		output quotient, remainder
	);

endinterface

`default_nettype wire

// File: common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	localparam int TAG_BITS = 4;

	// ==============================
	// Decode to execute

	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		logic [isa_pkg::XLEN-1:0] pc;
		logic [isa_pkg::XLEN-1:0] imm;
		isa_pkg::exec_class_e exec_class;
		isa_pkg::alu_op_e alu_op;
		isa_pkg::operand_sel_e operand1_sel;
		isa_pkg::operand_sel_e operand2_sel;
		isa_pkg::muldiv_op_e muldiv_op;
		logic [4:0] rd_index;
		logic [1:0] mem_width;
		logic mem_signed;
	} decode_data_t;

	// ==============================
	// Execute to memory

	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		logic [4:0] rd_index;
		logic [isa_pkg::XLEN-1:0] rd;
		logic mem_read;
		logic mem_write;
		logic [1:0] mem_width;
		logic mem_signed;
		logic [isa_pkg::XLEN-1:0] mem_address;
	} execute_data_t;

endpackage

`default_nettype wire

// File: common/isa_pkg.sv
`default_nettype none

package isa_pkg;

	localparam int XLEN = 32;

	// One quotient bit per divider step
	localparam int DIV_STEPS = XLEN;

	typedef enum logic [3:0] {
		CLASS_NONE    = 4'd0,
		CLASS_ARITH   = 4'd1,
		CLASS_SHIFT   = 4'd2,
		CLASS_COMPARE = 4'd3,
		CLASS_JUMP    = 4'd4,
		CLASS_BRANCH  = 4'd5,
		CLASS_LOAD    = 4'd6,
		CLASS_STORE   = 4'd7,
		CLASS_MULDIV  = 4'd8
	} exec_class_e;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_XOR = 4'd2,
		ALU_OR  = 4'd3,
		ALU_AND = 4'd4,
		ALU_SLL = 4'd5,
		ALU_SRL = 4'd6,
		ALU_SRA = 4'd7,
		ALU_EQ  = 4'd8,
		ALU_NE  = 4'd9,
		ALU_LT  = 4'd10,
		ALU_GE  = 4'd11,
		ALU_LTU = 4'd12,
		ALU_GEU = 4'd13
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_ZERO = 3'd0,
		SEL_RS1  = 3'd1,
		SEL_RS2  = 3'd2,
		SEL_PC   = 3'd3,
		SEL_IMM  = 3'd4
	} operand_sel_e;

	typedef enum logic [2:0] {
		MD_MUL   = 3'd0,
		MD_MULH  = 3'd1,
		MD_MULHU = 3'd2,
		MD_DIV   = 3'd3,
		MD_DIVU  = 3'd4,
		MD_REM   = 3'd5,
		MD_REMU  = 3'd6
	} muldiv_op_e;

endpackage

`default_nettype wire
